/* source/sprite_pkg.sv */
package sprite_pkg;

    // entity table size
    localparam int num_entities = 9;

    // screen geometry in tiles and pixels
    localparam int tiles_h = 16;
    localparam int tiles_v = 12;
    localparam int tile_pixels = 40;
    localparam int upscale = 5;
    localparam int screen_w = tiles_h * tile_pixels;
    localparam int screen_h = tiles_v * tile_pixels;

    // sprite rom shape
    localparam int num_sprites = 16;
    localparam int sprite_rows = 8;
    localparam int rom_depth = num_sprites * sprite_rows;
    localparam int rom_multiplier = 37;

    // axi4-lite bus widths
    localparam int axi_addr_w = 6;
    localparam int axi_data_w = 32;

    typedef logic [axi_addr_w-1:0] axi_addr_t;
    typedef logic [axi_data_w-1:0] axi_data_t;
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    typedef logic [9:0] coord_t;
    // id in 13:10, orientation in 9:8, tile in 7:0
    typedef logic [13:0] entity_t;
    typedef logic [3:0] sprite_id_t;
    typedef logic [7:0] tile_t;
    typedef logic [2:0] sub_t;

    typedef enum logic [1:0] {
        orient_normal     = 2'd0,
        orient_mirror_h   = 2'd1,
        orient_mirror_v   = 2'd2,
        orient_rotate_180 = 2'd3
    } orient_t;

    typedef entity_t entity_table_t [num_entities];

    localparam sprite_id_t sprite_none = 4'd15;
    // empty slot, id 15 with normal orientation at tile 0
    localparam entity_t entity_unused = 14'h3c00;

    function automatic sprite_id_t entity_id(input entity_t ent);
        return ent[13:10];
    endfunction

    function automatic orient_t entity_orient(input entity_t ent);
        return orient_t'(ent[9:8]);
    endfunction

    function automatic tile_t entity_tile(input entity_t ent);
        return ent[7:0];
    endfunction

    // generated pattern byte for one sprite row
    // bit c is pixel column c from the left
    function automatic logic [7:0] rom_byte(input sprite_id_t id, input sub_t row);
        int unsigned prod;
        prod = rom_multiplier * (int'(id) * sprite_rows + int'(row));
        return prod[7:0];
    endfunction

endpackage

/* source/sprite_hit_if.sv */
interface sprite_hit_if;

    // pixel covered by an entity this cycle
    logic hit;
    sprite_pkg::sprite_id_t sprite_id;
    sprite_pkg::orient_t orient;
    // row and column inside the 8x8 bitmap
    sprite_pkg::sub_t row;
    sprite_pkg::sub_t col;

    modport detector (
        output hit,
        output sprite_id,
        output orient,
        output row,
        output col
    );

    modport renderer (
        input hit,
        input sprite_id,
        input orient,
        input row,
        input col
    );

endinterface

/* source/entity_regs.sv */
module entity_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  sprite_pkg::axi_addr_t     awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  sprite_pkg::axi_data_t     wdata,
    input  logic [3:0]                wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output sprite_pkg::resp_t         bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  sprite_pkg::axi_addr_t     araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output sprite_pkg::axi_data_t     rdata,
    output sprite_pkg::resp_t         rresp,
    output sprite_pkg::entity_table_t entities
);

    logic [3:0] aw_slot;
    logic [3:0] ar_slot;
    logic aw_ok;
    logic ar_ok;
    logic wr_fire;
    logic rd_fire;
    sprite_pkg::entity_table_t table_q;

    // slot k lives at byte address 4k, anything else is a bad address
    function automatic logic slot_ok(input sprite_pkg::axi_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr[sprite_pkg::axi_addr_w-1:2] < sprite_pkg::num_entities);
    endfunction

    assign aw_slot = awaddr[sprite_pkg::axi_addr_w-1:2];
    assign ar_slot = araddr[sprite_pkg::axi_addr_w-1:2];
    assign aw_ok = slot_ok(awaddr);
    assign ar_ok = slot_ok(araddr);

    // aw and w are taken together in one beat
    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    // write address/data ready and b response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= sprite_pkg::resp_okay;
        end else begin
            // one-cycle ready pulse, held off while b is pending
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp <= aw_ok ? sprite_pkg::resp_okay : sprite_pkg::resp_slverr;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // entity registers
    // whole word is written, wstrb not applied
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < sprite_pkg::num_entities; k++) begin
                table_q[k] <= sprite_pkg::entity_unused;
            end
        end else if (wr_fire && aw_ok) begin
            table_q[aw_slot] <= wdata[13:0];
        end
    end

    // read address ready and r response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rresp <= sprite_pkg::resp_okay;
        end else begin
            // held off while r is pending
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp <= ar_ok ? sprite_pkg::resp_okay : sprite_pkg::resp_slverr;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data is captured with the ar beat
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            // zero-extended word, zero on a bad address
            rdata <= ar_ok ? sprite_pkg::axi_data_t'(table_q[ar_slot]) : '0;
        end
    end

    assign entities = table_q;

endmodule

/* source/entity_detector.sv */
module entity_detector (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sprite_pkg::coord_t        counter_h,
    input  sprite_pkg::coord_t        counter_v,
    input  sprite_pkg::entity_table_t entities,
    sprite_hit_if.detector            hit_out
);

    sprite_pkg::coord_t tile_col;
    sprite_pkg::coord_t tile_row;
    sprite_pkg::tile_t tile;
    logic in_screen;
    logic found;
    sprite_pkg::entity_t win;

    // tile under the raster position
    assign tile_col = sprite_pkg::coord_t'(counter_h / sprite_pkg::tile_pixels);
    assign tile_row = sprite_pkg::coord_t'(counter_v / sprite_pkg::tile_pixels);
    // row major tile number, 16 tiles per row
    assign tile = sprite_pkg::tile_t'(tile_row * sprite_pkg::tiles_h + tile_col);

    // blanking area never shows a sprite
    assign in_screen = (counter_h < sprite_pkg::screen_w) && (counter_v < sprite_pkg::screen_h);

    // priority search over the table
    always_comb begin
        found = 1'b0;
        win = sprite_pkg::entity_unused;
        for (int k = 0; k < sprite_pkg::num_entities; k++) begin
            // lowest slot on this tile wins
            if (!found
                && sprite_pkg::entity_id(entities[k]) != sprite_pkg::sprite_none
                && sprite_pkg::entity_tile(entities[k]) == tile) begin
                found = 1'b1;
                win = entities[k];
            end
        end
    end

    // hit flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_out.hit <= 1'b0;
        end else begin
            hit_out.hit <= found && in_screen;
        end
    end

    // sprite selection and position inside the bitmap
    always_ff @(posedge clk) begin
        hit_out.sprite_id <= sprite_pkg::entity_id(win);
        hit_out.orient <= sprite_pkg::entity_orient(win);
        // each bitmap pixel covers 5x5 screen pixels
        hit_out.row <= sprite_pkg::sub_t'((counter_v % sprite_pkg::tile_pixels) / sprite_pkg::upscale);
        hit_out.col <= sprite_pkg::sub_t'((counter_h % sprite_pkg::tile_pixels) / sprite_pkg::upscale);
    end

endmodule

/* source/sprite_renderer.sv */
module sprite_renderer (
    input  logic           clk,
    input  logic           rst_n,
    sprite_hit_if.renderer hit_in,
    output logic           colour
);

    logic [7:0] pattern_rom [sprite_pkg::rom_depth];
    sprite_pkg::sub_t row_adj;
    sprite_pkg::sub_t col_adj;
    logic [7:0] line;
    logic mirror_v;
    logic mirror_h;

    // pattern rom, 8 rows per sprite, indexed by {id, row}
    for (genvar g = 0; g < sprite_pkg::rom_depth; g++) begin : g_rom
        assign pattern_rom[g] = sprite_pkg::rom_byte(
            sprite_pkg::sprite_id_t'(g / sprite_pkg::sprite_rows),
            sprite_pkg::sub_t'(g % sprite_pkg::sprite_rows)
        );
    end

    // rotate_180 flips both axes
    assign mirror_v = (hit_in.orient == sprite_pkg::orient_mirror_v)
                   || (hit_in.orient == sprite_pkg::orient_rotate_180);
    assign mirror_h = (hit_in.orient == sprite_pkg::orient_mirror_h)
                   || (hit_in.orient == sprite_pkg::orient_rotate_180);

    always_comb begin
        // top-bottom flip picks the opposite row
        row_adj = mirror_v ? ~hit_in.row : hit_in.row;
        // left-right flip reads the byte from the other end
        col_adj = mirror_h ? ~hit_in.col : hit_in.col;
        line = pattern_rom[{hit_in.sprite_id, row_adj}];
    end

    // white background where no entity covers the pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            colour <= 1'b1;
        end else if (hit_in.hit) begin
            colour <= line[col_adj];
        end else begin
            colour <= 1'b1;
        end
    end

endmodule

/* source/frame_buffer_controller.sv */
module frame_buffer_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  sprite_pkg::axi_addr_t awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  sprite_pkg::axi_data_t wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output sprite_pkg::resp_t     bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  sprite_pkg::axi_addr_t araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output sprite_pkg::axi_data_t rdata,
    output sprite_pkg::resp_t     rresp,
    input  sprite_pkg::coord_t    counter_h,
    input  sprite_pkg::coord_t    counter_v,
    // 1 white, 0 black
    output logic                  colour
);

    sprite_pkg::entity_table_t entities;
    sprite_hit_if hit_bus ();

    // host side entity table
    entity_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .entities (entities)
    );

    // first pipeline stage
    entity_detector detector_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .counter_h (counter_h),
        .counter_v (counter_v),
        .entities  (entities),
        .hit_out   (hit_bus.detector)
    );

    // second pipeline stage
    sprite_renderer renderer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .hit_in (hit_bus.renderer),
        .colour (colour)
    );

endmodule

/* test/tb_frame_buffer_controller.sv */
module tb_frame_buffer_controller;

    timeunit 1ns;
    timeprecision 1ps;

    // test lengths
    localparam int clk_period = 40;
    localparam int reset_cycles = 3;
    localparam int reset_walk_len = 300;
    localparam int walk_len = 1500;
    localparam int walk_rounds = 2;
    localparam int random_writes = 30;
    localparam int bad_ops = 6;
    localparam int tile_sweeps = 6;
    localparam int tile_area = 40 * 40;
    localparam int max_stall = 7;
    localparam int handshake_limit = 8;
    // worst case cycles of one axi transfer including the response stall
    localparam int op_cycles = 16;
    localparam int axi_ops = 3 * 9 + walk_rounds * 9 + 2 * random_writes + 2 * bad_ops + 8;
    localparam int sweep_cycles = reset_walk_len + walk_rounds * walk_len
                                + tile_sweeps * tile_area + (1 + walk_rounds + tile_sweeps) * 2;
    localparam int watchdog_ns = (axi_ops * op_cycles + sweep_cycles + reset_cycles)
                               * clk_period * 2;

    logic clk = 1'b0;
    logic rst_n;
    logic awvalid;
    logic awready;
    sprite_pkg::axi_addr_t awaddr;
    logic wvalid;
    logic wready;
    sprite_pkg::axi_data_t wdata;
    logic [3:0] wstrb;
    logic bvalid;
    logic bready;
    sprite_pkg::resp_t bresp;
    logic arvalid;
    logic arready;
    sprite_pkg::axi_addr_t araddr;
    logic rvalid;
    logic rready;
    sprite_pkg::axi_data_t rdata;
    sprite_pkg::resp_t rresp;
    sprite_pkg::coord_t counter_h;
    sprite_pkg::coord_t counter_v;
    logic colour;

    // reference copy of the entity table
    logic [13:0] model_table [9];
    // predicted colours still in the two-stage pipeline
    logic exp_q [$];
    logic [31:0] lfsr_state = 32'he295_0632;

    frame_buffer_controller dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .counter_h (counter_h),
        .counter_v (counter_v),
        .colour    (colour)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] time %0t ns: %s expected 0x%0h actual 0x%0h",
                 $time, name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_bits(16)) % n;
    endfunction

    // expected pixel for one raster position
    function automatic logic model_colour(input int h, input int v);
        int tile;
        int slot;
        int row;
        int col;
        int id;
        logic [1:0] orient;
        logic [7:0] pattern;
        if (h >= 640 || v >= 480) begin
            return 1'b1;
        end
        tile = (v / 40) * 16 + h / 40;
        slot = -1;
        // walk down so the lowest matching slot is kept
        for (int k = 8; k >= 0; k--) begin
            if (model_table[k][13:10] != 4'hf && int'(model_table[k][7:0]) == tile) begin
                slot = k;
            end
        end
        if (slot < 0) begin
            return 1'b1;
        end
        id = int'(model_table[slot][13:10]);
        orient = model_table[slot][9:8];
        // 5x upscale inside the 40 pixel tile
        row = (v % 40) / 5;
        col = (h % 40) / 5;
        if (orient[1]) begin
            row = 7 - row;
        end
        if (orient[0]) begin
            col = 7 - col;
        end
        // generated artwork, 37 * (8 * id + row)
        pattern = 8'((37 * (8 * id + row)) % 256);
        return pattern[col];
    endfunction

    // check the oldest prediction, then drive the next position
    task automatic step_raster(input int h, input int v);
        logic expected;
        @(negedge clk);
        if (exp_q.size() == 2) begin
            expected = exp_q.pop_front();
            assert (colour == expected)
                else report_mismatch("colour", 32'(expected), 32'(colour));
        end
        counter_h = sprite_pkg::coord_t'(h);
        counter_v = sprite_pkg::coord_t'(v);
        exp_q.push_back(model_colour(h, v));
    endtask

    task automatic drain_pipeline();
        logic expected;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            expected = exp_q.pop_front();
            assert (colour == expected)
                else report_mismatch("colour", 32'(expected), 32'(colour));
        end
    endtask

    // mix of random jumps, jumps into entity tiles and raster steps
    task automatic random_walk(input int len);
        int h;
        int v;
        int slot;
        int tile;
        h = 0;
        v = 0;
        for (int i = 0; i < len; i++) begin
            case (rand_bits(2))
                0: begin
                    h = int'(rand_bits(10));
                    v = int'(rand_bits(10));
                end
                1: begin
                    slot = rand_below(9);
                    tile = int'(model_table[slot][7:0]);
                    h = (tile % 16) * 40 + rand_below(40);
                    v = (tile / 16) * 40 + rand_below(40);
                end
                default: begin
                    // 800x525 total raster incl. blanking
                    h++;
                    if (h >= 800) begin
                        h = 0;
                        v = (v >= 524) ? 0 : v + 1;
                    end
                end
            endcase
            step_raster(h, v);
        end
        drain_pipeline();
    endtask

    // every pixel of one tile in raster order
    task automatic tile_sweep(input int tile);
        int base_h;
        int base_v;
        base_h = (tile % 16) * 40;
        base_v = (tile / 16) * 40;
        for (int r = 0; r < 40; r++) begin
            for (int c = 0; c < 40; c++) begin
                step_raster(base_h + c, base_v + r);
            end
        end
        drain_pipeline();
    endtask

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        int stall;
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        // strobes are ignored by the slave
        wstrb = 4'(rand_bits(4));
        awvalid = 1'b1;
        wvalid = 1'b1;
        waited = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            waited++;
            assert (waited < handshake_limit)
                else report_error("write address and data were never accepted");
        end
        // handshake on the coming rising edge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        waited = 0;
        while (!bvalid) begin
            @(negedge clk);
            waited++;
            assert (waited < handshake_limit)
                else report_error("write response never arrived");
        end
        stall = rand_below(max_stall + 1);
        repeat (stall) begin
            @(negedge clk);
            assert (bvalid) else report_error("bvalid dropped before bready was raised");
        end
        resp = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        assert (!bvalid) else report_error("bvalid still high after the response was taken");
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        int stall;
        logic [31:0] first;
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        waited = 0;
        while (!arready) begin
            @(negedge clk);
            waited++;
            assert (waited < handshake_limit)
                else report_error("read address was never accepted");
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited = 0;
        while (!rvalid) begin
            @(negedge clk);
            waited++;
            assert (waited < handshake_limit)
                else report_error("read data never arrived");
        end
        first = rdata;
        stall = rand_below(max_stall + 1);
        repeat (stall) begin
            @(negedge clk);
            assert (rvalid) else report_error("rvalid dropped before rready was raised");
            // data must hold while stalled
            assert (rdata == first) else report_mismatch("rdata", first, rdata);
        end
        data = rdata;
        resp = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        assert (!rvalid) else report_error("rvalid still high after the data was taken");
    endtask

    // upper data bits are junk, only 13:0 must stick
    task automatic write_slot(input int slot, input logic [13:0] word);
        logic [1:0] resp;
        axi_write(6'(slot * 4), {18'(rand_bits(18)), word}, resp);
        assert (resp == 2'd0) else report_mismatch("bresp", 32'd0, 32'(resp));
        model_table[slot] = word;
    endtask

    task automatic check_slot(input int slot);
        logic [31:0] data;
        logic [1:0] resp;
        axi_read(6'(slot * 4), data, resp);
        assert (data == {18'd0, model_table[slot]})
            else report_mismatch("rdata", {18'd0, model_table[slot]}, data);
        assert (resp == 2'd0) else report_mismatch("rresp", 32'd0, 32'(resp));
    endtask

    function automatic logic [13:0] random_entity();
        logic [3:0] id;
        logic [1:0] orient;
        id = 4'(rand_bits(4));
        orient = 2'(rand_bits(2));
        // keep tiles on screen
        return {id, orient, 8'(rand_below(192))};
    endfunction

    initial begin
        #(watchdog_ns);
        report_error("watchdog expired, the test did not finish in time");
    end

    initial begin
        logic [31:0] data;
        logic [1:0] resp;
        logic [5:0] addr;
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        counter_h = '0;
        counter_v = '0;
        for (int k = 0; k < 9; k++) begin
            model_table[k] = 14'h3c00;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        // reset values
        assert (!awready) else report_mismatch("awready", 32'd0, 32'(awready));
        assert (!wready) else report_mismatch("wready", 32'd0, 32'(wready));
        assert (!arready) else report_mismatch("arready", 32'd0, 32'(arready));
        assert (!bvalid) else report_mismatch("bvalid", 32'd0, 32'(bvalid));
        assert (!rvalid) else report_mismatch("rvalid", 32'd0, 32'(rvalid));
        assert (colour) else report_mismatch("colour", 32'd1, 32'(colour));

        // empty table shows white everywhere
        random_walk(reset_walk_len);
        for (int k = 0; k < 9; k++) begin
            check_slot(k);
        end

        // random table writes with readback
        repeat (random_writes) begin
            int slot;
            slot = rand_below(9);
            write_slot(slot, 14'(rand_bits(14)));
            check_slot(slot);
        end

        // addresses past slot 8
        repeat (bad_ops) begin
            addr = 6'(36 + rand_below(28));
            axi_write(addr, rand_bits(32), resp);
            assert (resp == 2'd2) else report_mismatch("bresp", 32'd2, 32'(resp));
            addr = 6'(36 + rand_below(28));
            axi_read(addr, data, resp);
            assert (resp == 2'd2) else report_mismatch("rresp", 32'd2, 32'(resp));
            assert (data == 32'd0) else report_mismatch("rdata", 32'd0, data);
        end
        for (int k = 0; k < 9; k++) begin
            check_slot(k);
        end

        // random scenes with a random raster walk
        repeat (walk_rounds) begin
            for (int k = 0; k < 9; k++) begin
                write_slot(k, random_entity());
            end
            random_walk(walk_len);
        end

        // one sprite through all four orientations
        for (int k = 0; k < 9; k++) begin
            write_slot(k, 14'h3c00);
        end
        for (int o = 0; o < 4; o++) begin
            write_slot(0, {4'd6, 2'(o), 8'd87});
            tile_sweep(87);
        end

        // two slots on one tile, lower slot on top
        write_slot(0, 14'h3c00);
        write_slot(2, {4'd3, 2'd0, 8'd130});
        write_slot(5, {4'd10, 2'd1, 8'd130});
        tile_sweep(130);
        // freeing slot 2 uncovers slot 5
        write_slot(2, {4'hf, 2'd0, 8'd130});
        tile_sweep(130);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
source/sprite_pkg.sv
source/sprite_hit_if.sv
source/entity_regs.sv
source/entity_detector.sv
source/sprite_renderer.sv
source/frame_buffer_controller.sv
test/tb_frame_buffer_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, pass only if the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal \
    --top-module tb_frame_buffer_controller \
    -f project.f \
    && ./obj_dir/Vtb_frame_buffer_controller | tee /dev/stderr \
    | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
